// ==== mips_id.f ====
+incdir+rtl
rtl/id_pkg.sv
rtl/id_pipe_reg.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/operand_bypass.sv
rtl/branch_unit.sv
rtl/id_stage.sv
verif/id_stage_tb.sv

// ==== verif/id_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "id_defines.svh"

module id_stage_tb import id_pkg::*; ();

    localparam int ISSUE_TIMEOUT = 10;
    localparam int WATCHDOG_NS   = 200000;

    logic               clk;
    logic               rst;
    fetch_t             fetch;
    logic [`DATA_W-1:0] inst_rdata;
    logic               stall_id;
    logic               stall_ex;
    rf_write_t          ex_fwd;
    rf_write_t          mem_fwd;
    rf_write_t          wb_fwd;
    logic               ex_is_load;
    id_to_ex_t          id_to_ex;
    branch_t            br;
    logic               stallreq;

    integer             seed = 19;
    // expected architectural register contents
    logic [`DATA_W-1:0] reg_model [`REG_NUM];

    id_stage DUT (
        .clk        (clk),
        .rst        (rst),
        .fetch      (fetch),
        .inst_rdata (inst_rdata),
        .stall_id   (stall_id),
        .stall_ex   (stall_ex),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .id_to_ex   (id_to_ex),
        .br         (br),
        .stallreq   (stallreq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("simulation ran past its time limit");
    end

    task automatic check_ctrl(input string name, input id_to_ex_t exp, input id_to_ex_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error [%s] expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_branch(input string name, input branch_t exp, input branch_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error [%s] expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("** Error [%s] expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input funct_e fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_type(input opcode_e op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic rf_write_t fwd(input logic we, input logic [4:0] addr,
                                      input logic [31:0] data);
        return '{we: we, addr: addr, data: data};
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] r;
        r = $random(seed);
        return (r & 32'h0fff_fffc) | 32'h0000_1000;
    endfunction

    function automatic logic [31:0] model_read(input logic [4:0] idx);
        return (idx == 5'd0) ? 32'h0 : reg_model[idx];
    endfunction

    // operands come from the register model, no bus forwarding
    function automatic id_to_ex_t expect_bundle(input logic [31:0] pc, input logic [31:0] word,
                                                input alu_op_e alu, input src1_sel_e s1,
                                                input src2_sel_e s2, input logic we,
                                                input logic [4:0] waddr);
        id_to_ex_t e;
        e.pc       = pc;
        e.inst     = word;
        e.alu_op   = alu;
        e.src1_sel = s1;
        e.src2_sel = s2;
        e.rf_we    = we;
        e.rf_waddr = waddr;
        e.rs_value = model_read(word[25:21]);
        e.rt_value = model_read(word[20:16]);
        return e;
    endfunction

    function automatic logic [31:0] offset_target(input logic [31:0] pc, input logic [15:0] imm);
        return pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};
    endfunction

    function automatic logic [31:0] region_target(input logic [31:0] pc, input logic [25:0] idx);
        logic [31:0] pc4;
        pc4 = pc + 32'd4;
        return {pc4[31:28], idx, 2'b00};
    endfunction

    // pc goes in first, the word follows one cycle later
    task automatic issue(input logic [31:0] pc, input logic [31:0] word, input logic hold);
        int cycles;
        cycles = 0;
        @(negedge clk);
        fetch      = '{valid: 1'b1, pc: pc};
        inst_rdata = $random(seed);
        @(negedge clk);
        while (id_to_ex.pc !== pc) begin
            if (cycles == ISSUE_TIMEOUT) begin
                abort_run("fetched pc never reached the decode register");
            end
            cycles++;
            @(negedge clk);
        end
        fetch.valid = 1'b0;
        inst_rdata  = word;
        stall_id    = hold;
        stall_ex    = hold;
        #1;
    endtask

    task automatic release_stage();
        @(negedge clk);
        stall_id   = 1'b0;
        stall_ex   = 1'b0;
        ex_is_load = 1'b0;
        ex_fwd     = '0;
        mem_fwd    = '0;
        wb_fwd     = '0;
    endtask

    task automatic drive_fwd(input rf_write_t ex, input rf_write_t mem, input rf_write_t wb);
        @(negedge clk);
        ex_fwd  = ex;
        mem_fwd = mem;
        wb_fwd  = wb;
        // wb also lands in the register file on the next edge
        if (wb.we && wb.addr != 5'd0) begin
            reg_model[wb.addr] = wb.data;
        end
        #1;
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        wb_fwd = fwd(1'b1, addr, data);
        @(negedge clk);
        wb_fwd = '0;
        if (addr != 5'd0) begin
            reg_model[addr] = data;
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        #1;
        check_bit("reset rf_we", 1'b0, id_to_ex.rf_we);
        check_bit("reset alu_op none", 1'b1, id_to_ex.alu_op == ALU_NONE);
        check_bit("reset taken", 1'b0, br.taken);
        check_bit("reset stallreq", 1'b0, stallreq);
    endtask

    task automatic test_regfile();
        logic [31:0] word;
        logic [31:0] pc;
        for (int i = 0; i < `REG_NUM; i++) begin
            write_reg(i[4:0], $random(seed));
        end
        for (int i = 0; i < `REG_NUM; i++) begin
            word = r_type(i[4:0], 5'(31 - i), 5'd0, 5'd0, FN_ADDU);
            pc   = rand_pc();
            issue(pc, word, 1'b0);
            check_ctrl("regfile readback", expect_bundle(pc, word, ALU_ADD, SRC1_RS, SRC2_RT,
                       1'b1, 5'd0), id_to_ex);
        end
    endtask

    task automatic test_forwarding();
        logic [31:0] word;
        logic [31:0] pc;
        id_to_ex_t   exp;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a    = $random(seed);
        b    = $random(seed);
        c    = $random(seed);
        pc   = rand_pc();
        word = r_type(5'd5, 5'd6, 5'd3, 5'd0, FN_ADDU);
        issue(pc, word, 1'b1);
        exp = expect_bundle(pc, word, ALU_ADD, SRC1_RS, SRC2_RT, 1'b1, 5'd3);
        exp.rs_value = a;
        drive_fwd(fwd(1'b1, 5'd5, a), fwd(1'b1, 5'd5, b), fwd(1'b1, 5'd5, c));
        check_ctrl("fwd ex first", exp, id_to_ex);
        exp.rs_value = b;
        drive_fwd(fwd(1'b0, 5'd5, a), fwd(1'b1, 5'd5, b), fwd(1'b1, 5'd5, c));
        check_ctrl("fwd mem over wb", exp, id_to_ex);
        exp.rs_value = c;
        drive_fwd(fwd(1'b0, 5'd5, a), fwd(1'b0, 5'd5, b), fwd(1'b1, 5'd5, c));
        check_ctrl("fwd wb only", exp, id_to_ex);
        drive_fwd('0, '0, '0);
        check_ctrl("wb value in regfile", exp, id_to_ex);
        release_stage();

        pc   = rand_pc();
        word = r_type(5'd0, 5'd7, 5'd3, 5'd0, FN_ADDU);
        issue(pc, word, 1'b1);
        drive_fwd(fwd(1'b1, 5'd0, a), fwd(1'b1, 5'd0, b), fwd(1'b1, 5'd0, c));
        check_ctrl("fwd zero ignored", expect_bundle(pc, word, ALU_ADD, SRC1_RS, SRC2_RT,
                   1'b1, 5'd3), id_to_ex);
        release_stage();
    endtask

    task automatic alu_r(input string name, input funct_e fn, input alu_op_e alu,
                         input src1_sel_e s1);
        logic [31:0] rnd;
        logic [31:0] word;
        logic [31:0] pc;
        rnd  = $random(seed);
        word = r_type(rnd[4:0], rnd[9:5], rnd[14:10], rnd[19:15], fn);
        pc   = rand_pc();
        issue(pc, word, 1'b0);
        check_ctrl(name, expect_bundle(pc, word, alu, s1, SRC2_RT, 1'b1, rnd[14:10]), id_to_ex);
    endtask

    task automatic alu_i(input string name, input opcode_e op, input alu_op_e alu,
                         input src2_sel_e s2);
        logic [31:0] rnd;
        logic [31:0] word;
        logic [31:0] pc;
        rnd  = $random(seed);
        word = i_type(op, rnd[4:0], rnd[9:5], rnd[31:16]);
        pc   = rand_pc();
        issue(pc, word, 1'b0);
        check_ctrl(name, expect_bundle(pc, word, alu, SRC1_RS, s2, 1'b1, rnd[9:5]), id_to_ex);
    endtask

    task automatic test_alu();
        repeat (3) begin
            alu_r("sll", FN_SLL, ALU_SLL, SRC1_SA);
            alu_r("srl", FN_SRL, ALU_SRL, SRC1_SA);
            alu_r("sra", FN_SRA, ALU_SRA, SRC1_SA);
            alu_r("sllv", FN_SLLV, ALU_SLL, SRC1_RS);
            alu_r("srlv", FN_SRLV, ALU_SRL, SRC1_RS);
            alu_r("srav", FN_SRAV, ALU_SRA, SRC1_RS);
            alu_r("addu", FN_ADDU, ALU_ADD, SRC1_RS);
            alu_r("subu", FN_SUBU, ALU_SUB, SRC1_RS);
            alu_r("and", FN_AND, ALU_AND, SRC1_RS);
            alu_r("or", FN_OR, ALU_OR, SRC1_RS);
            alu_r("xor", FN_XOR, ALU_XOR, SRC1_RS);
            alu_r("nor", FN_NOR, ALU_NOR, SRC1_RS);
            alu_r("slt", FN_SLT, ALU_SLT, SRC1_RS);
            alu_r("sltu", FN_SLTU, ALU_SLTU, SRC1_RS);
            alu_i("addiu", OP_ADDIU, ALU_ADD, SRC2_IMM_SIGN);
            alu_i("slti", OP_SLTI, ALU_SLT, SRC2_IMM_SIGN);
            alu_i("sltiu", OP_SLTIU, ALU_SLTU, SRC2_IMM_SIGN);
            alu_i("andi", OP_ANDI, ALU_AND, SRC2_IMM_ZERO);
            alu_i("ori", OP_ORI, ALU_OR, SRC2_IMM_ZERO);
            alu_i("xori", OP_XORI, ALU_XOR, SRC2_IMM_ZERO);
            alu_i("lui", OP_LUI, ALU_LUI, SRC2_IMM_ZERO);
        end
    endtask

    // conditional branch with a random offset; link forms must not write
    task automatic cond_branch(input string name, input opcode_e op, input logic [4:0] rs,
                               input logic [4:0] rt, input logic exp_taken);
        logic [31:0] rnd;
        logic [31:0] word;
        logic [31:0] pc;
        logic        link;
        rnd  = $random(seed);
        word = i_type(op, rs, rt, rnd[15:0]);
        pc   = rand_pc();
        // bltzal and bgezal have rt 16 and 17
        link = (op == OP_REGIMM) && rt[4];
        issue(pc, word, 1'b0);
        check_branch(name, '{taken: exp_taken, target: offset_target(pc, rnd[15:0])}, br);
        if (link) begin
            check_ctrl({name, " link"}, expect_bundle(pc, word, ALU_ADD, SRC1_PC, SRC2_EIGHT,
                       1'b0, 5'(`LINK_REG)), id_to_ex);
        end else begin
            check_ctrl({name, " ctrl"}, expect_bundle(pc, word, ALU_NONE, SRC1_RS, SRC2_RT,
                       1'b0, 5'd0), id_to_ex);
        end
    endtask

    task automatic test_branches();
        logic [31:0] rnd;
        logic [31:0] word;
        logic [31:0] pc;
        write_reg(5'd1, 32'd5);
        write_reg(5'd2, 32'd5);
        write_reg(5'd3, 32'hffff_fffd);
        write_reg(5'd4, 32'd0);
        write_reg(5'd5, 32'd7);
        write_reg(5'd6, 32'h0040_1230);
        cond_branch("beq equal", OP_BEQ, 5'd1, 5'd2, 1'b1);
        cond_branch("beq differ", OP_BEQ, 5'd1, 5'd5, 1'b0);
        cond_branch("bne differ", OP_BNE, 5'd1, 5'd5, 1'b1);
        cond_branch("bne equal", OP_BNE, 5'd1, 5'd2, 1'b0);
        cond_branch("blez neg", OP_BLEZ, 5'd3, 5'd0, 1'b1);
        cond_branch("blez zero", OP_BLEZ, 5'd4, 5'd0, 1'b1);
        cond_branch("blez pos", OP_BLEZ, 5'd5, 5'd0, 1'b0);
        cond_branch("bgtz pos", OP_BGTZ, 5'd5, 5'd0, 1'b1);
        cond_branch("bgtz zero", OP_BGTZ, 5'd4, 5'd0, 1'b0);
        cond_branch("bgtz neg", OP_BGTZ, 5'd3, 5'd0, 1'b0);
        cond_branch("bltz neg", OP_REGIMM, 5'd3, 5'd0, 1'b1);
        cond_branch("bltz pos", OP_REGIMM, 5'd5, 5'd0, 1'b0);
        cond_branch("bgez zero", OP_REGIMM, 5'd4, 5'd1, 1'b1);
        cond_branch("bgez neg", OP_REGIMM, 5'd3, 5'd1, 1'b0);
        cond_branch("bltzal neg", OP_REGIMM, 5'd3, 5'd16, 1'b1);
        cond_branch("bgezal pos", OP_REGIMM, 5'd5, 5'd17, 1'b1);

        rnd  = $random(seed);
        word = {OP_J, rnd[25:0]};
        pc   = rand_pc();
        issue(pc, word, 1'b0);
        check_branch("j", '{taken: 1'b1, target: region_target(pc, rnd[25:0])}, br);

        rnd  = $random(seed);
        word = {OP_JAL, rnd[25:0]};
        pc   = rand_pc();
        issue(pc, word, 1'b0);
        check_branch("jal", '{taken: 1'b1, target: region_target(pc, rnd[25:0])}, br);
        check_ctrl("jal link", expect_bundle(pc, word, ALU_ADD, SRC1_PC, SRC2_EIGHT, 1'b1,
                   5'(`LINK_REG)), id_to_ex);

        word = r_type(5'd6, 5'd0, 5'd0, 5'd0, FN_JR);
        pc   = rand_pc();
        issue(pc, word, 1'b0);
        check_branch("jr", '{taken: 1'b1, target: 32'h0040_1230}, br);
        check_bit("jr no write", 1'b0, id_to_ex.rf_we);

        word = r_type(5'd6, 5'd0, 5'd9, 5'd0, FN_JALR);
        pc   = rand_pc();
        issue(pc, word, 1'b0);
        check_branch("jalr", '{taken: 1'b1, target: 32'h0040_1230}, br);
        check_ctrl("jalr link", expect_bundle(pc, word, ALU_ADD, SRC1_PC, SRC2_EIGHT, 1'b1,
                   5'd9), id_to_ex);
    endtask

    task automatic test_stalls();
        logic [31:0] word;
        logic [31:0] pc;
        id_to_ex_t   exp;
        branch_t     exp_br;
        // decode stalled alone
        pc   = rand_pc();
        word = r_type(5'd1, 5'd2, 5'd4, 5'd0, FN_OR);
        issue(pc, word, 1'b1);
        check_bit("before bubble rf_we", 1'b1, id_to_ex.rf_we);
        @(negedge clk);
        stall_ex = 1'b0;
        @(negedge clk);
        #1;
        check_bit("bubble rf_we", 1'b0, id_to_ex.rf_we);
        check_bit("bubble alu_op none", 1'b1, id_to_ex.alu_op == ALU_NONE);
        release_stage();

        // both stalled, memory output wanders
        pc     = rand_pc();
        word   = i_type(OP_BEQ, 5'd1, 5'd2, 16'hfff0);
        issue(pc, word, 1'b1);
        exp    = expect_bundle(pc, word, ALU_NONE, SRC1_RS, SRC2_RT, 1'b0, 5'd0);
        exp_br = '{taken: 1'b1, target: offset_target(pc, 16'hfff0)};
        check_ctrl("hold start", exp, id_to_ex);
        repeat (3) begin
            @(negedge clk);
            inst_rdata = $random(seed);
            #1;
            check_ctrl("hold bundle", exp, id_to_ex);
            check_branch("hold branch", exp_br, br);
        end
        release_stage();

        // load-use
        pc   = rand_pc();
        word = r_type(5'd8, 5'd9, 5'd4, 5'd0, FN_ADDU);
        issue(pc, word, 1'b1);
        @(negedge clk);
        ex_is_load = 1'b1;
        drive_fwd(fwd(1'b1, 5'd9, 32'h1), '0, '0);
        check_bit("load-use rt", 1'b1, stallreq);
        drive_fwd(fwd(1'b1, 5'd8, 32'h2), '0, '0);
        check_bit("load-use rs", 1'b1, stallreq);
        drive_fwd(fwd(1'b1, 5'd10, 32'h3), '0, '0);
        check_bit("load other reg", 1'b0, stallreq);
        @(negedge clk);
        ex_is_load = 1'b0;
        drive_fwd(fwd(1'b1, 5'd9, 32'h4), '0, '0);
        check_bit("no load no stall", 1'b0, stallreq);
        release_stage();
    endtask

    initial begin
        rst        = 1'b1;
        fetch      = '0;
        inst_rdata = '0;
        stall_id   = 1'b0;
        stall_ex   = 1'b0;
        ex_fwd     = '0;
        mem_fwd    = '0;
        wb_fwd     = '0;
        ex_is_load = 1'b0;
        for (int i = 0; i < `REG_NUM; i++) begin
            reg_model[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_regfile();
        test_forwarding();
        test_alu();
        test_branches();
        test_stalls();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/id_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "id_defines.svh"

module id_stage import id_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  fetch_t             fetch,
    input  logic [`DATA_W-1:0] inst_rdata,
    input  logic               stall_id,
    input  logic               stall_ex,
    input  rf_write_t          ex_fwd,
    input  rf_write_t          mem_fwd,
    input  rf_write_t          wb_fwd,
    input  logic               ex_is_load,
    output id_to_ex_t          id_to_ex,
    output branch_t            br,
    output logic               stallreq
);

    logic [`DATA_W-1:0] cur_pc;
    logic               cur_valid;
    logic [`DATA_W-1:0] inst;
    dec_ctrl_t          ctrl;
    logic [`REG_AW-1:0] rs_idx;
    logic [`REG_AW-1:0] rt_idx;
    logic [`DATA_W-1:0] rf_rs;
    logic [`DATA_W-1:0] rf_rt;
    logic [`DATA_W-1:0] rs_value;
    logic [`DATA_W-1:0] rt_value;

    id_pipe_reg u_pipe_reg (
        .clk        (clk),
        .rst        (rst),
        .stall_id   (stall_id),
        .stall_ex   (stall_ex),
        .fetch      (fetch),
        .inst_rdata (inst_rdata),
        .cur_pc     (cur_pc),
        .cur_valid  (cur_valid),
        .inst       (inst)
    );

    inst_decoder u_decoder (
        .inst   (inst),
        .ctrl   (ctrl),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .wr     (wb_fwd),
        .raddr1 (rs_idx),
        .raddr2 (rt_idx),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt)
    );

    operand_bypass u_bypass (
        .rs_idx     (rs_idx),
        .rt_idx     (rt_idx),
        .rf_rs      (rf_rs),
        .rf_rt      (rf_rt),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .stallreq   (stallreq)
    );

    branch_unit u_branch (
        .pc       (cur_pc),
        .inst     (inst),
        .br_kind  (ctrl.br_kind),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .br       (br)
    );

    // a bubble decodes as sll $0, so kill its controls here
    assign id_to_ex = '{
        pc:       cur_pc,
        inst:     inst,
        alu_op:   cur_valid ? ctrl.alu_op : ALU_NONE,
        src1_sel: ctrl.src1_sel,
        src2_sel: ctrl.src2_sel,
        rf_we:    cur_valid && ctrl.rf_we,
        rf_waddr: ctrl.rf_waddr,
        rs_value: rs_value,
        rt_value: rt_value
    };

endmodule

`default_nettype wire

// ==== rtl/branch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "id_defines.svh"

module branch_unit import id_pkg::*; (
    input  logic [`DATA_W-1:0] pc,
    input  logic [`DATA_W-1:0] inst,
    input  br_kind_e           br_kind,
    input  logic [`DATA_W-1:0] rs_value,
    input  logic [`DATA_W-1:0] rt_value,
    output branch_t            br
);

    logic [`DATA_W-1:0] pc_plus4;
    logic [`DATA_W-1:0] br_target;
    logic [`DATA_W-1:0] jump_target;
    logic               rs_eq_rt;
    logic               rs_neg;
    logic               rs_zero;

    assign pc_plus4 = pc + `DATA_W'(`PC_STEP);

    // word offset, sign extended
    assign br_target = pc_plus4 + {{(`DATA_W-`IMM_MSB-3){inst[`IMM_MSB]}},
                                   inst[`IMM_MSB:0], 2'b00};

    // stays inside the 256 MB region of the delay slot
    assign jump_target = {pc_plus4[`DATA_W-1 -: 4], inst[`INDEX_MSB:0], 2'b00};

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_neg   = rs_value[`DATA_W-1];
    assign rs_zero  = (rs_value == '0);

    always_comb begin
        br.taken  = 1'b0;
        br.target = br_target;
        case (br_kind)
            BR_BEQ:  br.taken = rs_eq_rt;
            BR_BNE:  br.taken = !rs_eq_rt;
            BR_BGEZ: br.taken = !rs_neg;
            BR_BGTZ: br.taken = !rs_neg && !rs_zero;
            BR_BLEZ: br.taken = rs_neg || rs_zero;
            BR_BLTZ: br.taken = rs_neg;
            BR_J: begin
                br.taken  = 1'b1;
                br.target = jump_target;
            end
            BR_JR: begin
                br.taken  = 1'b1;
                br.target = rs_value;
            end
            default: br.target = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/operand_bypass.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "id_defines.svh"

module operand_bypass import id_pkg::*; (
    input  logic [`REG_AW-1:0] rs_idx,
    input  logic [`REG_AW-1:0] rt_idx,
    input  logic [`DATA_W-1:0] rf_rs,
    input  logic [`DATA_W-1:0] rf_rt,
    input  rf_write_t          ex_fwd,
    input  rf_write_t          mem_fwd,
    input  rf_write_t          wb_fwd,
    input  logic               ex_is_load,
    output logic [`DATA_W-1:0] rs_value,
    output logic [`DATA_W-1:0] rt_value,
    output logic               stallreq
);

    // a write to $zero is never forwarded
    function automatic logic fwd_hit(input rf_write_t fwd, input logic [`REG_AW-1:0] idx);
        return fwd.we && (idx != '0) && (fwd.addr == idx);
    endfunction

    // youngest producer first
    function automatic logic [`DATA_W-1:0] pick(input logic [`REG_AW-1:0] idx,
                                                input logic [`DATA_W-1:0] rf_val);
        if (fwd_hit(ex_fwd, idx)) begin
            return ex_fwd.data;
        end else if (fwd_hit(mem_fwd, idx)) begin
            return mem_fwd.data;
        end else if (fwd_hit(wb_fwd, idx)) begin
            return wb_fwd.data;
        end
        return rf_val;
    endfunction

    assign rs_value = pick(rs_idx, rf_rs);
    assign rt_value = pick(rt_idx, rf_rt);

    // load data is not ready until MEM, hold decode one cycle
    assign stallreq = ex_is_load && (fwd_hit(ex_fwd, rs_idx) || fwd_hit(ex_fwd, rt_idx));

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "id_defines.svh"

module regfile import id_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  rf_write_t          wr,
    input  logic [`REG_AW-1:0] raddr1,
    input  logic [`REG_AW-1:0] raddr2,
    output logic [`DATA_W-1:0] rdata1,
    output logic [`DATA_W-1:0] rdata2
);

    logic [`DATA_W-1:0] regs [`REG_NUM];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // $zero is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "id_defines.svh"

module inst_decoder import id_pkg::*; (
    input  logic [`DATA_W-1:0] inst,
    output dec_ctrl_t          ctrl,
    output logic [`REG_AW-1:0] rs_idx,
    output logic [`REG_AW-1:0] rt_idx
);

    // REGIMM sub-opcodes live in the rt field
    localparam logic [`REG_AW-1:0] RI_BLTZ   = 5'd0;
    localparam logic [`REG_AW-1:0] RI_BGEZ   = 5'd1;
    localparam logic [`REG_AW-1:0] RI_BLTZAL = 5'd16;
    localparam logic [`REG_AW-1:0] RI_BGEZAL = 5'd17;

    opcode_e            opcode;
    funct_e             funct;
    logic [`REG_AW-1:0] rd_idx;
    logic               link;

    assign opcode = opcode_e'(inst[`OPC_MSB:`OPC_LSB]);
    assign funct  = funct_e'(inst[`FUNC_MSB:`FUNC_LSB]);
    assign rs_idx = inst[`RS_MSB:`RS_LSB];
    assign rt_idx = inst[`RT_MSB:`RT_LSB];
    assign rd_idx = inst[`RD_MSB:`RD_LSB];

    always_comb begin
        ctrl.alu_op   = ALU_NONE;
        ctrl.src1_sel = SRC1_RS;
        ctrl.src2_sel = SRC2_RT;
        ctrl.rf_we    = 1'b0;
        ctrl.rf_waddr = '0;
        ctrl.br_kind  = BR_NONE;
        link          = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL: begin
                        ctrl.alu_op   = ALU_SLL;
                        ctrl.src1_sel = SRC1_SA;
                    end
                    FN_SRL: begin
                        ctrl.alu_op   = ALU_SRL;
                        ctrl.src1_sel = SRC1_SA;
                    end
                    FN_SRA: begin
                        ctrl.alu_op   = ALU_SRA;
                        ctrl.src1_sel = SRC1_SA;
                    end
                    FN_SLLV: ctrl.alu_op = ALU_SLL;
                    FN_SRLV: ctrl.alu_op = ALU_SRL;
                    FN_SRAV: ctrl.alu_op = ALU_SRA;
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_NOR:  ctrl.alu_op = ALU_NOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    FN_JR:   ctrl.br_kind = BR_JR;
                    FN_JALR: begin
                        ctrl.br_kind = BR_JR;
                        link         = 1'b1;
                    end
                    default: ;
                endcase
                // all R-type writers target rd
                ctrl.rf_we    = link || (ctrl.alu_op != ALU_NONE);
                ctrl.rf_waddr = ctrl.rf_we ? rd_idx : '0;
            end
            OP_REGIMM: begin
                case (rt_idx)
                    RI_BLTZ: ctrl.br_kind = BR_BLTZ;
                    RI_BGEZ: ctrl.br_kind = BR_BGEZ;
                    RI_BLTZAL: begin
                        ctrl.br_kind  = BR_BLTZ;
                        ctrl.rf_waddr = `REG_AW'(`LINK_REG);
                        link          = 1'b1;
                    end
                    RI_BGEZAL: begin
                        ctrl.br_kind  = BR_BGEZ;
                        ctrl.rf_waddr = `REG_AW'(`LINK_REG);
                        link          = 1'b1;
                    end
                    default: ;
                endcase
            end
            OP_J:    ctrl.br_kind = BR_J;
            OP_JAL: begin
                ctrl.br_kind  = BR_J;
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = `REG_AW'(`LINK_REG);
                link          = 1'b1;
            end
            OP_BEQ:  ctrl.br_kind = BR_BEQ;
            OP_BNE:  ctrl.br_kind = BR_BNE;
            OP_BLEZ: ctrl.br_kind = BR_BLEZ;
            OP_BGTZ: ctrl.br_kind = BR_BGTZ;
            OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                ctrl.alu_op   = (opcode == OP_ADDIU) ? ALU_ADD :
                                (opcode == OP_SLTI)  ? ALU_SLT : ALU_SLTU;
                ctrl.src2_sel = SRC2_IMM_SIGN;
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = rt_idx;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.alu_op   = (opcode == OP_ANDI) ? ALU_AND :
                                (opcode == OP_ORI)  ? ALU_OR  :
                                (opcode == OP_XORI) ? ALU_XOR : ALU_LUI;
                ctrl.src2_sel = SRC2_IMM_ZERO;
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = rt_idx;
            end
            default: ;
        endcase

        // return address is pc + 8, past the delay slot
        if (link) begin
            ctrl.alu_op   = ALU_ADD;
            ctrl.src1_sel = SRC1_PC;
            ctrl.src2_sel = SRC2_EIGHT;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/id_pipe_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "id_defines.svh"

module id_pipe_reg import id_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall_id,
    input  logic               stall_ex,
    input  fetch_t             fetch,
    input  logic [`DATA_W-1:0] inst_rdata,
    output logic [`DATA_W-1:0] cur_pc,
    output logic               cur_valid,
    output logic [`DATA_W-1:0] inst
);

    fetch_t             fetch_q;
    logic               buf_valid;
    logic [`DATA_W-1:0] buf_inst;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_q   <= '0;
            buf_valid <= 1'b0;
        end else if (!stall_id) begin
            fetch_q   <= fetch;
            buf_valid <= 1'b0;
        end else if (!stall_ex) begin
            // decode stalled alone, send a bubble downstream
            fetch_q   <= '0;
            buf_valid <= 1'b0;
        end else if (!buf_valid) begin
            buf_valid <= 1'b1;
        end
    end

    // memory returns the word only once, keep it for the rest of the hold
    always_ff @(posedge clk) begin
        if (stall_id && stall_ex && !buf_valid) begin
            buf_inst <= inst_rdata;
        end
    end

    assign cur_pc    = fetch_q.pc;
    assign cur_valid = fetch_q.valid;
    assign inst      = !fetch_q.valid ? '0 : (buf_valid ? buf_inst : inst_rdata);

endmodule

`default_nettype wire

// ==== rtl/id_pkg.sv ====
`default_nettype none

`include "id_defines.svh"

package id_pkg;

    // primary opcodes
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // function field of SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS, SRC1_PC, SRC1_SA} src1_sel_e;

    typedef enum logic [1:0] {SRC2_RT, SRC2_IMM_SIGN, SRC2_IMM_ZERO, SRC2_EIGHT} src2_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_J, BR_JR
    } br_kind_e;

    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] pc;
    } fetch_t;

    // one register write, used for forwarding and writeback
    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] addr;
        logic [`DATA_W-1:0] data;
    } rf_write_t;

    typedef struct packed {
        alu_op_e            alu_op;
        src1_sel_e          src1_sel;
        src2_sel_e          src2_sel;
        logic               rf_we;
        logic [`REG_AW-1:0] rf_waddr;
        br_kind_e           br_kind;
    } dec_ctrl_t;

    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] inst;
        alu_op_e            alu_op;
        src1_sel_e          src1_sel;
        src2_sel_e          src2_sel;
        logic               rf_we;
        logic [`REG_AW-1:0] rf_waddr;
        logic [`DATA_W-1:0] rs_value;
        logic [`DATA_W-1:0] rt_value;
    } id_to_ex_t;

    typedef struct packed {
        logic               taken;
        logic [`DATA_W-1:0] target;
    } branch_t;

endpackage

`default_nettype wire

// ==== rtl/id_defines.svh ====
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// datapath and pc width
`define DATA_W      32

// register file geometry
`define REG_AW      5
`define REG_NUM     32
`define LINK_REG    31

// instruction field positions
`define OPC_MSB     31
`define OPC_LSB     26
`define RS_MSB      25
`define RS_LSB      21
`define RT_MSB      20
`define RT_LSB      16
`define RD_MSB      15
`define RD_LSB      11
`define SA_MSB      10
`define SA_LSB      6
`define FUNC_MSB    5
`define FUNC_LSB    0
`define IMM_MSB     15
`define INDEX_MSB   25

// sequential pc increment
`define PC_STEP     4

`endif
